// File: verilog/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Region field in address bits 31..28
`define SOC_REGION_W 4
`define SOC_REGION_RAM 1
`define SOC_REGION_BRIDGE 5

// Far side of the peripheral bridge
`define SOC_FAR_ADDR_W 28
`define SOC_FAR_TIMER 0
`define SOC_FAR_DMA 7

// Block RAM depth in words
`define SOC_RAM_WORDS 1024

// Peripheral register word offsets
`define SOC_REG_IDX_W 2
`define TMR_COUNT 0
`define TMR_COMPARE 1
`define TMR_CTRL 2
`define DMA_SRC 0
`define DMA_DST 1
`define DMA_LEN 2
`define DMA_CTRL 3

`endif

// File: verilog/soc_pkg.sv
`include "soc_defs.svh"

package soc_pkg;

	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_DATA_W-1:0] data_t;
	typedef logic [`SOC_REGION_W-1:0] region_t;
	typedef logic [`SOC_REG_IDX_W-1:0] reg_idx_t;

	// Request toward a slave, rw high for write
	typedef struct packed {
		logic request;
		logic rw;
		addr_t address;
		data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		data_t rdata;
	} bus_rsp_t;

	// Instruction fetch is read only
	typedef struct packed {
		logic request;
		addr_t address;
	} fetch_req_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_t;

endpackage

// File: verilog/bus_access.sv
`timescale 1ns/10ps

module bus_access (
	input  logic                 clock,
	input  logic                 i_rst_n,

	// Port A, instruction fetch
	input  soc_pkg::fetch_req_t  i_pa_req,
	output soc_pkg::bus_rsp_t    o_pa_rsp,

	// Port B, data
	input  soc_pkg::bus_req_t    i_pb_req,
	output soc_pkg::bus_rsp_t    o_pb_rsp,

	// Port C, DMA engine
	input  soc_pkg::bus_req_t    i_pc_req,
	output soc_pkg::bus_rsp_t    o_pc_rsp,

	// Single system bus
	output soc_pkg::bus_req_t    o_bus_req,
	input  soc_pkg::bus_rsp_t    i_bus_rsp
);
	import soc_pkg::*;

	localparam logic [1:0] PORT_A = 2'd0;
	localparam logic [1:0] PORT_B = 2'd1;
	localparam logic [1:0] PORT_C = 2'd2;

	arb_state_t state;
	logic [1:0] grant;

	//========================================
	// Grant FSM

	// Fixed priority B, then C, then A
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ARB_IDLE;
			grant <= PORT_A;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (i_pb_req.request) begin
						grant <= PORT_B;
						state <= ARB_BUSY;
					end else if (i_pc_req.request) begin
						grant <= PORT_C;
						state <= ARB_BUSY;
					end else if (i_pa_req.request) begin
						grant <= PORT_A;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					// One transaction per grant
					if (i_bus_rsp.ready)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	//========================================
	// System bus request

	always_comb begin
		case (grant)
			PORT_B: o_bus_req = i_pb_req;
			PORT_C: o_bus_req = i_pc_req;
			default: begin
				// Fetch never writes
				o_bus_req.request = i_pa_req.request;
				o_bus_req.rw = 1'b0;
				o_bus_req.address = i_pa_req.address;
				o_bus_req.wdata = '0;
			end
		endcase
		if (state != ARB_BUSY)
			o_bus_req.request = 1'b0;
	end

	//========================================
	// Response routing

	// Only the granted port sees ready and data
	always_comb begin
		o_pa_rsp = '0;
		o_pb_rsp = '0;
		o_pc_rsp = '0;
		if (state == ARB_BUSY) begin
			case (grant)
				PORT_B: o_pb_rsp = i_bus_rsp;
				PORT_C: o_pc_rsp = i_bus_rsp;
				default: o_pa_rsp = i_bus_rsp;
			endcase
		end
	end

endmodule

// File: verilog/block_ram.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module block_ram (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

	data_t mem [`SOC_RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic access;
	logic ready_q;
	data_t rdata_q;

	// Word index, upper address bits wrap
	assign idx = i_req.address[IDX_W+1:2];

	// No second access while our ready is out
	assign access = i_req.request && !ready_q;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= access;
	end

	//========================================
	// Storage

	always_ff @(posedge clock) begin
		if (access) begin
			if (i_req.rw)
				mem[idx] <= i_req.wdata;
			rdata_q <= mem[idx];
		end
	end

	always_comb begin
		o_rsp.ready = ready_q;
		o_rsp.rdata = rdata_q;
	end

endmodule

// File: verilog/periph_bridge.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module periph_bridge (
	input  logic               clock,
	input  logic               i_rst_n,

	// Near side, system bus
	input  soc_pkg::bus_req_t  i_near_req,
	output soc_pkg::bus_rsp_t  o_near_rsp,

	// Far side, peripherals
	output soc_pkg::bus_req_t  o_far_req,
	input  soc_pkg::bus_rsp_t  i_far_rsp
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_FAR,
		BR_DONE
	} br_state_t;

	br_state_t state;
	logic cap_rw;
	logic [`SOC_FAR_ADDR_W-1:0] cap_addr;
	data_t cap_wdata;
	data_t cap_rdata;

	// Capture, wait on far side, then one near ready
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= BR_IDLE;
		end else begin
			case (state)
				BR_IDLE: if (i_near_req.request) state <= BR_FAR;
				BR_FAR: if (i_far_rsp.ready) state <= BR_DONE;
				// Near request is still held here, so skip it
				default: state <= BR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == BR_IDLE && i_near_req.request) begin
			cap_rw <= i_near_req.rw;
			cap_addr <= i_near_req.address[`SOC_FAR_ADDR_W-1:0];
			cap_wdata <= i_near_req.wdata;
		end
		if (state == BR_FAR && i_far_rsp.ready)
			cap_rdata <= i_far_rsp.rdata;
	end

	always_comb begin
		o_far_req.request = (state == BR_FAR);
		o_far_req.rw = cap_rw;
		o_far_req.address = addr_t'(cap_addr);
		o_far_req.wdata = cap_wdata;

		o_near_rsp.ready = (state == BR_DONE);
		o_near_rsp.rdata = cap_rdata;
	end

endmodule

// File: verilog/soc_timer.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module soc_timer (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp,
	output logic               o_irq
);
	import soc_pkg::*;

	data_t count;
	data_t compare;
	logic enable;
	logic ready_q;
	data_t rdata_q;
	reg_idx_t reg_idx;
	logic access;
	logic wr;

	assign reg_idx = i_req.address[`SOC_REG_IDX_W+1:2];
	assign access = i_req.request && !ready_q;
	assign wr = access && i_req.rw;

	//========================================
	// Counter and registers

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			enable <= 1'b0;
			count <= '0;
			compare <= '0;
		end else begin
			ready_q <= access;
			// Counter load wins over counting
			if (wr && reg_idx == `TMR_COUNT)
				count <= i_req.wdata;
			else if (enable)
				count <= count + 1'b1;
			if (wr && reg_idx == `TMR_COMPARE)
				compare <= i_req.wdata;
			if (wr && reg_idx == `TMR_CTRL)
				enable <= i_req.wdata[0];
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (reg_idx)
				`TMR_COUNT: rdata_q <= count;
				`TMR_COMPARE: rdata_q <= compare;
				`TMR_CTRL: rdata_q <= data_t'(enable);
				default: rdata_q <= '0;
			endcase
		end
	end

	// Level interrupt, follows count and compare directly
	assign o_irq = enable && (count >= compare);

	always_comb begin
		o_rsp.ready = ready_q;
		o_rsp.rdata = rdata_q;
	end

endmodule

// File: verilog/dma_engine.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module dma_engine (
	input  logic               clock,
	input  logic               i_rst_n,

	// Register port behind the bridge
	input  soc_pkg::bus_req_t  i_reg_req,
	output soc_pkg::bus_rsp_t  o_reg_rsp,

	// Master port toward the arbiter
	output soc_pkg::bus_req_t  o_bus_req,
	input  soc_pkg::bus_rsp_t  i_bus_rsp
);
	import soc_pkg::*;

	dma_state_t state;
	addr_t src;
	addr_t dst;
	data_t len;
	data_t word;
	data_t reg_rdata;
	logic reg_ready;
	reg_idx_t reg_idx;
	logic reg_access;
	logic busy;

	assign reg_idx = i_reg_req.address[`SOC_REG_IDX_W+1:2];
	assign reg_access = i_reg_req.request && !reg_ready;
	assign busy = (state != DMA_IDLE);

	//========================================
	// Copy FSM

	// Register writes only land while idle
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= DMA_IDLE;
			reg_ready <= 1'b0;
			src <= '0;
			dst <= '0;
			len <= '0;
		end else begin
			reg_ready <= reg_access;
			case (state)
				DMA_IDLE: begin
					if (reg_access && i_reg_req.rw) begin
						case (reg_idx)
							`DMA_SRC: src <= i_reg_req.wdata;
							`DMA_DST: dst <= i_reg_req.wdata;
							`DMA_LEN: len <= i_reg_req.wdata;
							// Zero length is done at once
							default: if (i_reg_req.wdata[0] && len != '0) state <= DMA_READ;
						endcase
					end
				end
				DMA_READ: begin
					if (i_bus_rsp.ready)
						state <= DMA_WRITE;
				end
				DMA_WRITE: begin
					if (i_bus_rsp.ready) begin
						src <= src + 32'd4;
						dst <= dst + 32'd4;
						len <= len - 1'b1;
						state <= (len == 32'd1) ? DMA_IDLE : DMA_READ;
					end
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reg_access) begin
			case (reg_idx)
				`DMA_SRC: reg_rdata <= src;
				`DMA_DST: reg_rdata <= dst;
				`DMA_LEN: reg_rdata <= len;
				default: reg_rdata <= data_t'(busy);
			endcase
		end
		if (state == DMA_READ && i_bus_rsp.ready)
			word <= i_bus_rsp.rdata;
	end

	always_comb begin
		o_reg_rsp.ready = reg_ready;
		o_reg_rsp.rdata = reg_rdata;

		o_bus_req.request = busy;
		o_bus_req.rw = (state == DMA_WRITE);
		o_bus_req.address = (state == DMA_WRITE) ? dst : src;
		o_bus_req.wdata = word;
	end

endmodule

// File: verilog/soc_fabric.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module soc_fabric (
	input  logic                 clock,
	input  logic                 i_rst_n,
	input  soc_pkg::fetch_req_t  i_ibus_req,
	output soc_pkg::bus_rsp_t    o_ibus_rsp,
	input  soc_pkg::bus_req_t    i_dbus_req,
	output soc_pkg::bus_rsp_t    o_dbus_rsp,
	output logic                 o_timer_irq
);
	import soc_pkg::*;

	bus_req_t sys_req;
	bus_rsp_t sys_rsp;
	bus_req_t dma_mst_req;
	bus_rsp_t dma_mst_rsp;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t near_req;
	bus_rsp_t near_rsp;
	bus_req_t far_req;
	bus_rsp_t far_rsp;
	bus_req_t timer_req;
	bus_rsp_t timer_rsp;
	bus_req_t dma_reg_req;
	bus_rsp_t dma_reg_rsp;

	region_t sys_region;
	region_t far_region;
	logic ram_sel;
	logic bridge_sel;
	logic unmapped_sel;
	logic timer_sel;
	logic dma_sel;
	logic unmapped_ready;

	bus_access bus0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_pa_req(i_ibus_req),
		.o_pa_rsp(o_ibus_rsp),
		.i_pb_req(i_dbus_req),
		.o_pb_rsp(o_dbus_rsp),
		.i_pc_req(dma_mst_req),
		.o_pc_rsp(dma_mst_rsp),
		.o_bus_req(sys_req),
		.i_bus_rsp(sys_rsp)
	);

	//========================================
	// System bus decode

	assign sys_region = sys_req.address[`SOC_ADDR_W-1 -: `SOC_REGION_W];
	assign ram_sel = (sys_region == `SOC_REGION_RAM);
	assign bridge_sel = (sys_region == `SOC_REGION_BRIDGE);
	assign unmapped_sel = !ram_sel && !bridge_sel;

	always_comb begin
		ram_req = sys_req;
		ram_req.request = sys_req.request && ram_sel;
		near_req = sys_req;
		near_req.request = sys_req.request && bridge_sel;
	end

	// Unmapped region answers next cycle with zero data
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= sys_req.request && unmapped_sel && !unmapped_ready;
	end

	always_comb begin
		if (ram_sel) begin
			sys_rsp = ram_rsp;
		end else if (bridge_sel) begin
			sys_rsp = near_rsp;
		end else begin
			sys_rsp.ready = unmapped_ready;
			sys_rsp.rdata = '0;
		end
	end

	block_ram ram0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_req(ram_req),
		.o_rsp(ram_rsp)
	);

	periph_bridge bridge0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_near_req(near_req),
		.o_near_rsp(near_rsp),
		.o_far_req(far_req),
		.i_far_rsp(far_rsp)
	);

	//========================================
	// Far bus decode

	assign far_region = far_req.address[`SOC_FAR_ADDR_W-1 -: `SOC_REGION_W];
	assign timer_sel = (far_region == `SOC_FAR_TIMER);
	assign dma_sel = (far_region == `SOC_FAR_DMA);

	always_comb begin
		timer_req = far_req;
		timer_req.request = far_req.request && timer_sel;
		dma_reg_req = far_req;
		dma_reg_req.request = far_req.request && dma_sel;

		if (timer_sel)
			far_rsp = timer_rsp;
		else if (dma_sel)
			far_rsp = dma_reg_rsp;
		else
			far_rsp = '0;
	end

	soc_timer timer0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_req(timer_req),
		.o_rsp(timer_rsp),
		.o_irq(o_timer_irq)
	);

	dma_engine dma0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_reg_req(dma_reg_req),
		.o_reg_rsp(dma_reg_rsp),
		.o_bus_req(dma_mst_req),
		.i_bus_rsp(dma_mst_rsp)
	);

endmodule

// File: test/tb_soc_fabric.sv
`timescale 1ns/10ps

module tb_soc_fabric;
	import soc_pkg::*;

	localparam int ACCESS_LIMIT = 200;
	localparam int MAX_OPS = 64;
	localparam int MAX_POLLS = 100;
	localparam int POLL_GAP = 16;

	logic clock;
	logic i_rst_n;
	fetch_req_t ibus_req;
	bus_rsp_t ibus_rsp;
	bus_req_t dbus_req;
	bus_rsp_t dbus_rsp;
	logic timer_irq;

	// Operations loaded from the data file
	reg [8*24-1:0] t_name [MAX_OPS];
	reg [8*8-1:0] t_op [MAX_OPS];
	addr_t t_addr [MAX_OPS];
	data_t t_data [MAX_OPS];
	data_t t_exp [MAX_OPS];

	// Source words of the DMA fill
	data_t fill_buf [64];
	int n_ops;
	int passed;
	int failed;
	logic loaded;

	soc_fabric dut0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ibus_req(ibus_req),
		.o_ibus_rsp(ibus_rsp),
		.i_dbus_req(dbus_req),
		.o_dbus_rsp(dbus_rsp),
		.o_timer_irq(timer_irq)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//========================================
	// Bus tasks

	// Drive on the falling edge and sample ready on the following ones
	task automatic dbus_access(input logic rw, input addr_t addr, input data_t wdata,
			output data_t rdata, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		rdata = '0;
		@(negedge clock);
		dbus_req.request = 1'b1;
		dbus_req.rw = rw;
		dbus_req.address = addr;
		dbus_req.wdata = wdata;
		while (!ok && cycles < ACCESS_LIMIT) begin
			@(negedge clock);
			cycles++;
			if (dbus_rsp.ready === 1'b1) begin
				ok = 1'b1;
				rdata = dbus_rsp.rdata;
			end
		end
		dbus_req.request = 1'b0;
		if (!ok)
			$display("Data port access to %h hung, no ready in %0d cycles", addr, ACCESS_LIMIT);
	endtask

	task automatic dbus_write(input addr_t addr, input data_t wdata, output logic ok);
		data_t unused;
		dbus_access(1'b1, addr, wdata, unused, ok);
	endtask

	task automatic dbus_read(input addr_t addr, output data_t rdata, output logic ok);
		dbus_access(1'b0, addr, '0, rdata, ok);
	endtask

	task automatic ibus_read(input addr_t addr, output data_t rdata, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		rdata = '0;
		@(negedge clock);
		ibus_req.request = 1'b1;
		ibus_req.address = addr;
		while (!ok && cycles < ACCESS_LIMIT) begin
			@(negedge clock);
			cycles++;
			if (ibus_rsp.ready === 1'b1) begin
				ok = 1'b1;
				rdata = ibus_rsp.rdata;
			end
		end
		ibus_req.request = 1'b0;
		if (!ok)
			$display("Fetch port read of %h hung, no ready in %0d cycles", addr, ACCESS_LIMIT);
	endtask

	task automatic report_value(input reg [8*24-1:0] name, input data_t expected,
			input data_t actual, input logic ok);
		if (!ok) begin
			$display("FAIL %0s, the bus access did not complete", name);
			failed++;
		end else if (actual !== expected) begin
			$display("CHECK FAILED %0s expected %h actual %h", name, expected, actual);
			failed++;
		end else begin
			$display("PASS %0s", name);
			passed++;
		end
	endtask

	//========================================
	// Test steps

	task automatic load_ops();
		int fd;
		int code;
		reg [8*24-1:0] tok;
		reg [8*8-1:0] op;
		reg [8*128-1:0] rest;
		data_t a;
		data_t d;
		data_t e;
		fd = $fopen("test/soc_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/soc_input.txt");
			failed++;
		end else begin
			while (!$feof(fd) && n_ops < MAX_OPS) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1 && tok == "#") begin
					code = $fgets(rest, fd);
				end else if (code == 1) begin
					code = $fscanf(fd, "%s %h %h %h", op, a, d, e);
					if (code == 4) begin
						t_name[n_ops] = tok;
						t_op[n_ops] = op;
						t_addr[n_ops] = a;
						t_data[n_ops] = d;
						t_exp[n_ops] = e;
						n_ops++;
					end
				end
			end
			$fclose(fd);
			if (n_ops == 0) begin
				$display("No test operations were read from test/soc_input.txt");
				failed++;
			end
		end
	endtask

	// Ready outputs and interrupt must stay low in and right after reset
	task automatic check_reset();
		data_t seen;
		seen = '0;
		repeat (4) begin
			@(negedge clock);
			seen = seen | {29'd0, ibus_rsp.ready, dbus_rsp.ready, timer_irq};
		end
		i_rst_n = 1'b1;
		repeat (2) begin
			@(negedge clock);
			seen = seen | {29'd0, ibus_rsp.ready, dbus_rsp.ready, timer_irq};
		end
		report_value("reset_state", '0, seen, 1'b1);
	endtask

	task automatic run_op(input int i);
		data_t rd;
		data_t rd2;
		logic ok;
		logic ok2;
		int polls;
		int bad_idx;
		ok = 1'b1;
		ok2 = 1'b1;
		rd = '0;
		rd2 = '0;
		polls = 0;
		bad_idx = -1;
		case (t_op[i])
			"W": begin
				dbus_write(t_addr[i], t_data[i], ok);
				report_value(t_name[i], '0, '0, ok);
			end
			"R": begin
				dbus_read(t_addr[i], rd, ok);
				report_value(t_name[i], t_exp[i], rd, ok);
			end
			"IR": begin
				// Fetch competes with the data port for the same word
				fork
					ibus_read(t_addr[i], rd, ok);
					dbus_read(t_addr[i], rd2, ok2);
				join
				report_value(t_name[i], t_exp[i], (rd2 !== t_exp[i]) ? rd2 : rd, ok && ok2);
			end
			"FILL": begin
				for (int k = 0; k < t_data[i] && k < 64; k++) begin
					fill_buf[k] = $urandom;
					dbus_write(t_addr[i] + 4 * k, fill_buf[k], ok2);
					ok = ok && ok2;
				end
				report_value(t_name[i], '0, '0, ok);
			end
			"POLL": begin
				rd = ~t_exp[i];
				while (ok && rd !== t_exp[i] && polls < MAX_POLLS) begin
					dbus_read(t_addr[i], rd, ok);
					polls++;
					// Idle gap so the lower priority DMA master wins the bus
					if (ok && rd !== t_exp[i])
						repeat (POLL_GAP) @(negedge clock);
				end
				if (ok && rd !== t_exp[i]) begin
					$display("FAIL %0s, DMA still busy after %0d polls", t_name[i], polls);
					failed++;
				end else begin
					report_value(t_name[i], t_exp[i], rd, ok);
				end
			end
			"COPY": begin
				for (int k = 0; k < t_data[i] && k < 64; k++) begin
					dbus_read(t_addr[i] + 4 * k, rd, ok2);
					ok = ok && ok2;
					if (bad_idx < 0 && rd !== fill_buf[k]) begin
						bad_idx = k;
						rd2 = rd;
					end
				end
				if (ok && bad_idx >= 0) begin
					$display("CHECK FAILED %0s word %0d expected %h actual %h",
						t_name[i], bad_idx, fill_buf[bad_idx], rd2);
					failed++;
				end else begin
					report_value(t_name[i], '0, '0, ok);
				end
			end
			"INC": begin
				dbus_read(t_addr[i], rd, ok);
				dbus_read(t_addr[i], rd2, ok2);
				if (ok && ok2 && rd2 <= rd) begin
					$display("CHECK FAILED %0s expected above %h actual %h", t_name[i], rd, rd2);
					failed++;
				end else begin
					report_value(t_name[i], '0, '0, ok && ok2);
				end
			end
			"IRQ": begin
				while (timer_irq !== t_exp[i][0] && polls < ACCESS_LIMIT) begin
					@(negedge clock);
					polls++;
				end
				report_value(t_name[i], t_exp[i], data_t'(timer_irq), 1'b1);
			end
			default: begin
				$display("FAIL %0s, unknown operation %0s", t_name[i], t_op[i]);
				failed++;
			end
		endcase
	endtask

	//========================================
	// Main sequence and watchdog

	initial begin
		i_rst_n = 1'b0;
		ibus_req = '0;
		dbus_req = '0;
		n_ops = 0;
		passed = 0;
		failed = 0;
		loaded = 1'b0;
		void'($urandom(67840));
		load_ops();
		loaded = 1'b1;
		check_reset();
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Budget of the access limit per operation plus slack
	initial begin
		wait (loaded === 1'b1);
		repeat (n_ops * ACCESS_LIMIT + 2000) @(posedge clock);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: test/soc_input.txt
# name op address data expected (hex), ops W R IR FILL POLL COPY INC IRQ
# FILL and COPY take a word count in the data column
ram_wr0      W    10000000 11112222 0
ram_wr1      W    10000004 33334444 0
ram_wr2      W    10000ffc a5a5a5a5 0
ram_rd0      R    10000000 0 11112222
ram_rd1      R    10000004 0 33334444
ram_wrap     R    10001ffc 0 a5a5a5a5
fetch_rd0    IR   10000000 0 11112222
fetch_rd1    IR   10000004 0 33334444
unmap_rd     R    90000000 0 00000000
unmap_wr     W    90000004 deadbeef 0
dst_guard    W    10000220 cafef00d 0
dma_fill     FILL 10000100 8 0
dma_src      W    57000000 10000100 0
dma_dst      W    57000004 10000200 0
dma_len      W    57000008 8 0
dma_start    W    5700000c 1 0
dma_poll     POLL 5700000c 0 0
dma_copy     COPY 10000200 8 0
dma_guard    R    10000220 0 cafef00d
tmr_cmp_wr   W    50000004 12345678 0
tmr_cmp_rd   R    50000004 0 12345678
tmr_enable   W    50000008 1 0
tmr_count    INC  50000000 0 0
tmr_count0   W    50000000 0 0
tmr_cmp_low  W    50000004 20 0
tmr_irq_on   IRQ  0 0 1
tmr_disable  W    50000008 0 0
tmr_irq_off  IRQ  0 0 0

// File: src.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_access.sv
verilog/block_ram.sv
verilog/periph_bridge.sv
verilog/soc_timer.sv
verilog/dma_engine.sv
verilog/soc_fabric.sv
test/tb_soc_fabric.sv
